/* include/coal_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coalescer configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COAL_CFG_SVH
`define COAL_CFG_SVH

// Lane and block geometry
`define COAL_NUM_LANES      4
`define COAL_WORD_BITS      32
`define COAL_BLOCK_WORDS    4
`define COAL_BLOCK_BYTES    16

// Accesses at or above this address are never merged
`define COAL_NONCACHE_BASE  32'hF000_0000

// Element width codes
`define COAL_EEW_8          2'd0
`define COAL_EEW_16         2'd1
`define COAL_EEW_32         2'd2

`endif

/* src/coal_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coalescer types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "coal_cfg.svh"

package coal_pkg;

    typedef logic [`COAL_WORD_BITS-1:0]            addr_t;
    typedef logic [`COAL_WORD_BITS-1:0]            word_t;
    typedef logic [`COAL_NUM_LANES-1:0]            lane_mask_t;
    typedef logic [$clog2(`COAL_NUM_LANES)-1:0]    lane_idx_t;
    typedef logic [1:0]                            eew_t;
    typedef logic [`COAL_BLOCK_BYTES-1:0]          byte_en_t;
    typedef logic [`COAL_BLOCK_WORDS*`COAL_WORD_BITS-1:0] block_data_t;

    // One vector memory instruction as seen from the lanes
    typedef struct packed {
        addr_t [`COAL_NUM_LANES-1:0] lane_addr;
        lane_mask_t                  lane_mask;
        word_t [`COAL_NUM_LANES-1:0] store_data;
        eew_t                        eew;
        logic                        write;
    } vec_req_t;

    // One block-wide access toward the data cache
    typedef struct packed {
        addr_t       block_addr;
        byte_en_t    byte_en;
        block_data_t store_data;
        lane_mask_t  lanes;
        logic        write;
    } mem_access_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

`default_nettype wire

/* src/lane_group_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Leader and block group decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "coal_cfg.svh"

module lane_group_decode
    import coal_pkg::*;
(
    input  addr_t [`COAL_NUM_LANES-1:0] lane_addr,
    input  lane_mask_t                  pending,
    output lane_idx_t                   leader,
    output lane_mask_t                  group
);

    localparam int OFF_BITS = $clog2(`COAL_BLOCK_BYTES);

    addr_t      lead_addr;
    lane_mask_t tag_match;
    lane_mask_t lead_bit;
    logic       noncache;

    // Lowest pending lane wins, so scan from the top down
    always_comb begin
        leader = '0;
        for (int i = `COAL_NUM_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                leader = lane_idx_t'(i);
            end
        end
    end

    assign lead_addr = lane_addr[leader];
    assign lead_bit  = (lane_mask_t'(1) << leader) & pending;

    // Same block when everything above the block offset agrees
    always_comb begin
        for (int i = 0; i < `COAL_NUM_LANES; i++) begin
            tag_match[i] = pending[i] &&
                (lane_addr[i][`COAL_WORD_BITS-1:OFF_BITS] ==
                 lead_addr[`COAL_WORD_BITS-1:OFF_BITS]);
        end
    end

    assign noncache = (lead_addr >= `COAL_NONCACHE_BASE);

    // Non-cacheable region is served one lane at a time
    assign group = noncache ? lead_bit : tag_match;

endmodule

`default_nettype wire

/* src/lane_issue_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane issue sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "coal_cfg.svh"

module lane_issue_seq
    import coal_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       req_valid,
    input  lane_mask_t lane_mask,
    input  lane_mask_t group,
    output lane_mask_t pending,
    output logic       req_ready,
    output logic       mem_valid,
    input  logic       mem_ready
);

    seq_state_t state;
    seq_state_t state_next;
    lane_mask_t pending_next;
    lane_mask_t remaining;
    logic       xfer;

    // Lanes still owed an access once the current group is out
    assign remaining = pending & ~group;

    assign mem_valid = (state == SEQ_ISSUE) && (pending != '0);
    assign xfer      = mem_valid && mem_ready;

    // Done on the last transfer, or at once for an empty mask
    assign req_ready = (state == SEQ_ISSUE) &&
                       ((pending == '0) || (xfer && (remaining == '0)));

    always_comb begin
        state_next   = state;
        pending_next = pending;
        case (state)
            SEQ_IDLE: begin
                if (req_valid) begin
                    state_next   = SEQ_ISSUE;
                    pending_next = lane_mask;
                end
            end
            SEQ_ISSUE: begin
                if (xfer) begin
                    pending_next = remaining;
                end
                if (req_ready) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next   = SEQ_IDLE;
                pending_next = '0;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state   <= SEQ_IDLE;
            pending <= '0;
        end else begin
            state   <= state_next;
            pending <= pending_next;
        end
    end

endmodule

`default_nettype wire

/* src/block_store_pack.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block store packer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "coal_cfg.svh"

module block_store_pack
    import coal_pkg::*;
(
    input  vec_req_t    req,
    input  lane_idx_t   leader,
    input  lane_mask_t  group,
    output mem_access_t access
);

    localparam int OFF_BITS = $clog2(`COAL_BLOCK_BYTES);

    logic [OFF_BITS-1:0] pos      [`COAL_NUM_LANES];
    logic [3:0]          lane_be  [`COAL_NUM_LANES];
    word_t               lane_bits[`COAL_NUM_LANES];
    byte_en_t            be;
    block_data_t         data;

    // Byte position and element size per lane
    always_comb begin
        for (int i = 0; i < `COAL_NUM_LANES; i++) begin
            pos[i]     = {req.lane_addr[i][OFF_BITS-1:2], 2'b00};
            lane_be[i] = 4'b1111;
            case (req.eew)
                `COAL_EEW_8: begin
                    pos[i]     = req.lane_addr[i][OFF_BITS-1:0];
                    lane_be[i] = 4'b0001;
                end
                `COAL_EEW_16: begin
                    pos[i]     = {req.lane_addr[i][OFF_BITS-1:1], 1'b0};
                    lane_be[i] = 4'b0011;
                end
                default: ;
            endcase
            lane_bits[i] = {{8{lane_be[i][3]}}, {8{lane_be[i][2]}},
                            {8{lane_be[i][1]}}, {8{lane_be[i][0]}}};
        end
    end

    // Merge group lanes, higher lanes overwrite lower ones on overlap
    always_comb begin
        be   = '0;
        data = '0;
        for (int i = 0; i < `COAL_NUM_LANES; i++) begin
            if (group[i]) begin
                be   = be | (byte_en_t'(lane_be[i]) << pos[i]);
                data = (data & ~(block_data_t'(lane_bits[i]) << {pos[i], 3'b000})) |
                       (block_data_t'(req.store_data[i] & lane_bits[i]) << {pos[i], 3'b000});
            end
        end
    end

    always_comb begin
        access.block_addr = req.lane_addr[leader] & ~addr_t'(`COAL_BLOCK_BYTES - 1);
        access.byte_en    = be;
        access.store_data = data;
        access.lanes      = group;
        access.write      = req.write;
    end

endmodule

`default_nettype wire

/* src/vmem_coalescer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector memory coalescer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "coal_cfg.svh"

module vmem_coalescer
    import coal_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  vec_req_t    req,
    input  logic        req_valid,
    output logic        req_ready,
    output mem_access_t mem,
    output logic        mem_valid,
    input  logic        mem_ready
);

    lane_idx_t  leader;
    lane_mask_t group;
    lane_mask_t pending;

    lane_group_decode u_decode (
        .lane_addr (req.lane_addr),
        .pending   (pending),
        .leader    (leader),
        .group     (group)
    );

    lane_issue_seq u_seq (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .lane_mask (req.lane_mask),
        .group     (group),
        .pending   (pending),
        .req_ready (req_ready),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready)
    );

    // Held stable by the sequencer while the cache stalls
    block_store_pack u_pack (
        .req       (req),
        .leader    (leader),
        .group     (group),
        .access    (mem)
    );

endmodule

`default_nettype wire

/* tb/tb_vmem_coalescer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coalescer testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "coal_cfg.svh"

module tb_vmem_coalescer
    import coal_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic        CLK = 1'b0;
    logic        nRST;
    vec_req_t    req;
    logic        req_valid;
    logic        req_ready;
    mem_access_t mem;
    logic        mem_valid;
    logic        mem_ready;

    // Expected access sequence of the request in flight
    mem_access_t exp_acc [0:7];
    int          exp_cnt;
    int          req_base;
    int          xfer_cnt;
    logic        busy;
    logic        xfer;
    logic        stalled;
    mem_access_t prev_mem;

    vmem_coalescer DUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .mem       (mem),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready)
    );

    always #10 CLK = ~CLK;

    assign xfer = mem_valid && mem_ready;

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            xfer_cnt <= 0;
            stalled  <= 1'b0;
            prev_mem <= '0;
        end else begin
            if (xfer) begin
                xfer_cnt <= xfer_cnt + 1;
            end
            stalled  <= mem_valid && !mem_ready;
            prev_mem <= mem;
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Cache side with random stalls
    initial begin
        mem_ready = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            mem_ready = ($urandom_range(0, 3) != 0);
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) !busy |-> !mem_valid && !req_ready)
        else stop_with_error($sformatf("FAILED at %0t: activity while no request is open", $time));

    assert property (@(posedge CLK) disable iff (!nRST)
        xfer |-> (xfer_cnt - req_base < exp_cnt) && (mem == exp_acc[xfer_cnt - req_base]))
        else stop_with_error($sformatf("FAILED at %0t: access differs from expected", $time));

    assert property (@(posedge CLK) disable iff (!nRST) stalled |-> mem_valid && mem == prev_mem)
        else stop_with_error($sformatf("FAILED at %0t: access changed during stall", $time));

    assert property (@(posedge CLK) disable iff (!nRST)
        req_ready |-> busy && (mem_valid ? (mem_ready && xfer_cnt - req_base == exp_cnt - 1)
                                         : (exp_cnt == 0)))
        else stop_with_error($sformatf("FAILED at %0t: req_ready at wrong cycle", $time));

    function automatic int elem_bytes(input eew_t e);
        case (e)
            `COAL_EEW_8:  return 1;
            `COAL_EEW_16: return 2;
            default:      return 4;
        endcase
    endfunction

    // Leader is the lowest pending lane, same block joins unless non-cacheable
    task automatic build_expected(input vec_req_t r);
        lane_mask_t  pend;
        lane_mask_t  grp;
        mem_access_t acc;
        int          lead;
        int          off;
        int          nbytes;
        exp_cnt = 0;
        pend    = r.lane_mask;
        nbytes  = elem_bytes(r.eew);
        while (pend != '0) begin
            lead = 0;
            while (!pend[lead]) begin
                lead++;
            end
            grp = '0;
            for (int i = 0; i < `COAL_NUM_LANES; i++) begin
                if (pend[i] && (r.lane_addr[i] / `COAL_BLOCK_BYTES ==
                                r.lane_addr[lead] / `COAL_BLOCK_BYTES)) begin
                    grp[i] = 1'b1;
                end
            end
            if (r.lane_addr[lead] >= `COAL_NONCACHE_BASE) begin
                grp       = '0;
                grp[lead] = 1'b1;
            end
            acc            = '0;
            acc.block_addr = r.lane_addr[lead] - (r.lane_addr[lead] % `COAL_BLOCK_BYTES);
            acc.lanes      = grp;
            acc.write      = r.write;
            for (int i = 0; i < `COAL_NUM_LANES; i++) begin
                if (grp[i]) begin
                    off = int'(r.lane_addr[i] % `COAL_BLOCK_BYTES);
                    for (int b = 0; b < nbytes; b++) begin
                        acc.byte_en[off + b]              = 1'b1;
                        acc.store_data[(off + b) * 8 +: 8] = r.store_data[i][b * 8 +: 8];
                    end
                end
            end
            exp_acc[exp_cnt] = acc;
            exp_cnt++;
            pend = pend & ~grp;
        end
    endtask

    function automatic vec_req_t make_request(input eew_t e, input addr_t a0, input addr_t a1,
                                              input addr_t a2, input addr_t a3,
                                              input lane_mask_t m);
        vec_req_t r;
        r.eew          = e;
        r.lane_mask    = m;
        r.write        = 1'($urandom_range(0, 1));
        r.lane_addr[0] = a0;
        r.lane_addr[1] = a1;
        r.lane_addr[2] = a2;
        r.lane_addr[3] = a3;
        for (int i = 0; i < `COAL_NUM_LANES; i++) begin
            r.store_data[i] = $urandom;
        end
        return r;
    endfunction

    // Few blocks per request so that lanes often share one
    function automatic vec_req_t random_request();
        vec_req_t r;
        addr_t    base;
        int       step;
        r    = make_request(eew_t'($urandom_range(0, 2)), '0, '0, '0, '0,
                            lane_mask_t'($urandom_range(0, 15)));
        step = elem_bytes(r.eew);
        base = ($urandom_range(0, 3) == 0) ? `COAL_NONCACHE_BASE + 32'h100
                                           : 32'h0000_2000 + ($urandom_range(0, 63) << 8);
        for (int i = 0; i < `COAL_NUM_LANES; i++) begin
            r.lane_addr[i] = base + $urandom_range(0, 2) * `COAL_BLOCK_BYTES
                             + ($urandom_range(0, 15) & ~(step - 1));
        end
        return r;
    endfunction

    // Called 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic run_request(input vec_req_t r);
        int cycles;
        build_expected(r);
        req_base  = xfer_cnt;
        req       = r;
        req_valid = 1'b1;
        busy      = 1'b1;
        cycles    = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!req_ready && cycles < WAIT_LIMIT);
        if (!req_ready) begin
            stop_with_error("Timeout: req_ready never rose to complete the request");
        end else begin
            @(posedge CLK);
            #1;
            req_valid = 1'b0;
            busy      = 1'b0;
            assert (xfer_cnt - req_base == exp_cnt)
                else stop_with_error($sformatf("FAILED at %0t: %0d accesses, expected %0d",
                                               $time, xfer_cnt - req_base, exp_cnt));
        end
    endtask

    initial begin
        vec_req_t r;
        void'($urandom(37));
        nRST      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        busy      = 1'b0;
        exp_cnt   = 0;
        req_base  = 0;
        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;
        repeat (4) @(posedge CLK);
        #1;
        r = make_request(`COAL_EEW_32, 32'h1000, 32'h1004, 32'h1008, 32'h100C, 4'b0000);
        run_request(r);
        // One shared block per element width
        for (int e = 0; e < 3; e++) begin
            r = make_request(eew_t'(e), 32'h1040, 32'h1040 + elem_bytes(eew_t'(e)),
                             32'h1040 + 2 * elem_bytes(eew_t'(e)),
                             32'h1040 + 3 * elem_bytes(eew_t'(e)), 4'b1111);
            run_request(r);
        end
        r = make_request(`COAL_EEW_16, 32'h3020, 32'h3000, 32'h3026, 32'h3010, 4'b1101);
        run_request(r);
        r = make_request(`COAL_EEW_32, 32'hF000_0100, 32'hF000_0104, 32'hF000_0108,
                         32'hF000_010C, 4'b1111);
        run_request(r);
        for (int n = 0; n < 80; n++) begin
            r = random_request();
            run_request(r);
        end
        repeat (3) @(posedge CLK);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/coal_pkg.sv
src/lane_group_decode.sv
src/lane_issue_seq.sv
src/block_store_pack.sv
src/vmem_coalescer.sv
tb/tb_vmem_coalescer.sv

/* Bender.yml */
package:
  name: vmem_coalescer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/coal_pkg.sv
      - src/lane_group_decode.sv
      - src/lane_issue_seq.sv
      - src/block_store_pack.sv
      - src/vmem_coalescer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_vmem_coalescer.sv
